//--- source/elink_defines.svh
// Shared e-link receiver constants, included by the RTL and the testbench wherever sizes, addresses or comma codes are needed
`ifndef ELINK_DEFINES_SVH
`define ELINK_DEFINES_SVH

// Receive FIFO size in stored words
`define ELINK_FIFO_DEPTH 16

// APB register map, byte addresses
`define ELINK_ADDR_DATA   4'h0  // Read pops one word
`define ELINK_ADDR_STATUS 4'h4  // Level, lock, counters
`define ELINK_ADDR_CTRL   4'h8  // Enable and counter clear

// K28.5 comma, bit a in bit 9, bit j in bit 0
`define ELINK_K28_5_NEG 10'b0011111010  // RD- form
`define ELINK_K28_5_POS 10'b1100000101  // RD+ form

// Decoded values of the frame delimiters
`define ELINK_K28_1 8'h3C  // Start of frame
`define ELINK_K28_6 8'hDC  // End of frame

`endif

//--- source/elink_pkg.sv
// Types shared by the e-link receiver stages and the testbench, referenced as elink_pkg::name
package elink_pkg;

  // Kind of a stored word, sits in DATA bits 9:8
  typedef enum logic [1:0] {
    kind_data = 2'd0,  // Plain data byte
    kind_sop  = 2'd1,  // K28.1 seen
    kind_eop  = 2'd2,  // K28.6 seen
    kind_err  = 2'd3   // Code or disparity error
  } sym_kind_e;

  // FIFO payload, also the low 10 bits of DATA
  typedef struct packed {
    sym_kind_e  kind;
    logic [7:0] data;  // Byte as HGFEDCBA
  } rx_word_t;

endpackage

//--- source/elink_deserializer.sv
// Deserializer for the 2-bit e-link, finds K28.5 alignment and hands aligned 10-bit symbols to the decoder
`timescale 1ns/1ps
`include "elink_defines.svh"

module elink_deserializer (
  input  logic       bitCLK,
  input  logic       rst,
  input  logic [1:0] elink_2bit,  // Bit 1 arrives first
  output logic [9:0] sym_10b,     // Bit a in bit 9
  output logic       sym_valid,
  output logic       locked
);

  logic [8:0]  hist;         // Previously received bits, newest in bit 0
  logic [10:0] window;       // History plus this cycle's pair
  logic [2:0]  cnt;          // Cycles since last emitted symbol
  logic        bit_off;      // 0 when symbols end on elink_2bit[0]
  logic        hit0;
  logic        hit1;
  logic        hit_cur;
  logic        aligned_end;
  logic        realign;
  logic        sel_off;

  assign window = {hist, elink_2bit};

  // Comma ending on the later bit of the pair
  assign hit0 = (window[9:0] == `ELINK_K28_5_NEG) ||
                (window[9:0] == `ELINK_K28_5_POS);
  // Comma ending on the earlier bit of the pair
  assign hit1 = (window[10:1] == `ELINK_K28_5_NEG) ||
                (window[10:1] == `ELINK_K28_5_POS);

  assign hit_cur     = bit_off ? hit1 : hit0;
  assign aligned_end = locked && (cnt == 3'd4);  // Fifth cycle of a symbol

  // Any comma off the current grid moves the grid
  assign realign = (hit0 || hit1) && !(aligned_end && hit_cur);
  assign sel_off = realign ? !hit0 : bit_off;  // Offset 0 wins a tie

  always_ff @(posedge bitCLK) begin
    if (rst) begin
      hist      <= '0;
      locked    <= 1'b0;
      bit_off   <= 1'b0;
      cnt       <= 3'd0;
      sym_valid <= 1'b0;
    end else begin
      hist      <= window[8:0];
      sym_valid <= realign || aligned_end;
      if (realign) begin
        locked  <= 1'b1;
        bit_off <= !hit0;
        cnt     <= 3'd0;  // Comma itself is the first symbol
      end else if (locked) begin
        cnt <= aligned_end ? 3'd0 : cnt + 3'd1;
      end
    end
  end

  // Symbol register, qualified by sym_valid
  always_ff @(posedge bitCLK) begin
    sym_10b <= sel_off ? window[10:1] : window[9:0];
  end

  // Symbols only leave an aligned receiver
  a_valid_needs_lock: assert property (
    @(posedge bitCLK) disable iff (rst) sym_valid |-> locked
  ) else $error("sym_valid without lock");

endmodule

//--- source/dec_8b10b.sv
// 8b10b symbol decoder with running disparity and code-error checking, one registered stage between aligner and FIFO
`timescale 1ns/1ps

module dec_8b10b (
  input  logic       bitCLK,
  input  logic       rst,
  input  logic [9:0] sym_10b,    // abcdeifghj, a in bit 9
  input  logic       sym_valid,
  output logic [7:0] dec_data,   // HGFEDCBA
  output logic       dec_k,
  output logic       dec_err,
  output logic       dec_valid
);

  logic [5:0] s6;        // abcdei
  logic [3:0] s4;        // fghj
  logic [3:0] s4_eff;    // fghj, inverted after the K28 RD+ prefix
  logic [5:0] r6;        // {ok, EDCBA}
  logic [3:0] r4;        // {ok, HGF}
  logic [2:0] p6;
  logic [2:0] p4;
  logic       rd;        // Running disparity, 1 is positive
  logic       rd_mid;
  logic       rd_out;
  logic       is_k28;
  logic       is_kx7;
  logic       disp_err;

  function automatic logic [2:0] ones(input logic [5:0] v);
    logic [2:0] n;
    n = 3'd0;
    for (int i = 0; i < 6; i++) begin
      n = n + {2'b00, v[i]};
    end
    return n;
  endfunction

  // 6b to 5b, both polarities
  function automatic logic [5:0] dec6(input logic [5:0] c);
    logic [5:0] r;
    case (c)
      6'b100111, 6'b011000: r = {1'b1, 5'd0};
      6'b011101, 6'b100010: r = {1'b1, 5'd1};
      6'b101101, 6'b010010: r = {1'b1, 5'd2};
      6'b110001:            r = {1'b1, 5'd3};
      6'b110101, 6'b001010: r = {1'b1, 5'd4};
      6'b101001:            r = {1'b1, 5'd5};
      6'b011001:            r = {1'b1, 5'd6};
      6'b111000, 6'b000111: r = {1'b1, 5'd7};
      6'b111001, 6'b000110: r = {1'b1, 5'd8};
      6'b100101:            r = {1'b1, 5'd9};
      6'b010101:            r = {1'b1, 5'd10};
      6'b110100:            r = {1'b1, 5'd11};
      6'b001101:            r = {1'b1, 5'd12};
      6'b101100:            r = {1'b1, 5'd13};
      6'b011100:            r = {1'b1, 5'd14};
      6'b010111, 6'b101000: r = {1'b1, 5'd15};
      6'b011011, 6'b100100: r = {1'b1, 5'd16};
      6'b100011:            r = {1'b1, 5'd17};
      6'b010011:            r = {1'b1, 5'd18};
      6'b110010:            r = {1'b1, 5'd19};
      6'b001011:            r = {1'b1, 5'd20};
      6'b101010:            r = {1'b1, 5'd21};
      6'b011010:            r = {1'b1, 5'd22};
      6'b111010, 6'b000101: r = {1'b1, 5'd23};
      6'b110011, 6'b001100: r = {1'b1, 5'd24};
      6'b100110:            r = {1'b1, 5'd25};
      6'b010110:            r = {1'b1, 5'd26};
      6'b110110, 6'b001001: r = {1'b1, 5'd27};
      6'b001110:            r = {1'b1, 5'd28};
      6'b001111, 6'b110000: r = {1'b1, 5'd28};  // K28 only
      6'b101110, 6'b010001: r = {1'b1, 5'd29};
      6'b011110, 6'b100001: r = {1'b1, 5'd30};
      6'b101011, 6'b010100: r = {1'b1, 5'd31};
      default:              r = {1'b0, 5'd0};   // Not a code
    endcase
    return r;
  endfunction

  // 4b to 3b, primary and alternate 7
  function automatic logic [3:0] dec4(input logic [3:0] c);
    logic [3:0] r;
    case (c)
      4'b1011, 4'b0100: r = {1'b1, 3'd0};
      4'b1001:          r = {1'b1, 3'd1};
      4'b0101:          r = {1'b1, 3'd2};
      4'b1100, 4'b0011: r = {1'b1, 3'd3};
      4'b1101, 4'b0010: r = {1'b1, 3'd4};
      4'b1010:          r = {1'b1, 3'd5};
      4'b0110:          r = {1'b1, 3'd6};
      4'b1110, 4'b0001: r = {1'b1, 3'd7};
      4'b0111, 4'b1000: r = {1'b1, 3'd7};
      default:          r = {1'b0, 3'd0};  // 0000 and 1111
    endcase
    return r;
  endfunction

  assign s6     = sym_10b[9:4];
  assign s4     = sym_10b[3:0];
  assign is_k28 = (s6 == 6'b001111) || (s6 == 6'b110000);
  assign s4_eff = (s6 == 6'b110000) ? ~s4 : s4;
  assign r6     = dec6(s6);
  assign r4     = dec4(s4_eff);
  assign p6     = ones(s6);
  assign p4     = ones({2'b00, s4});

  // K23.7, K27.7, K29.7, K30.7 use the alternate 7
  assign is_kx7 = ((s4 == 4'b0111) || (s4 == 4'b1000)) &&
                  (s6 inside {6'b111010, 6'b000101, 6'b110110, 6'b001001,
                              6'b101110, 6'b010001, 6'b011110, 6'b100001});

  always_comb begin
    // Unbalanced sub-blocks set disparity, so an error resyncs it too
    rd_mid   = (p6 > 3'd3) ? 1'b1 : ((p6 < 3'd3) ? 1'b0 : rd);
    rd_out   = (p4 > 3'd2) ? 1'b1 : ((p4 < 3'd2) ? 1'b0 : rd_mid);
    disp_err = 1'b0;
    if ((p6 > 3'd3 && rd) || (p6 < 3'd3 && !rd)) begin
      disp_err = 1'b1;
    end
    if ((s6 == 6'b111000 && rd) || (s6 == 6'b000111 && !rd)) begin
      disp_err = 1'b1;  // D.7 form picked by disparity
    end
    if ((p4 > 3'd2 && rd_mid) || (p4 < 3'd2 && !rd_mid)) begin
      disp_err = 1'b1;
    end
    if ((s4 == 4'b1100 && rd_mid) || (s4 == 4'b0011 && !rd_mid)) begin
      disp_err = 1'b1;  // Same rule for x.3
    end
  end

  always_ff @(posedge bitCLK) begin
    if (rst) begin
      dec_valid <= 1'b0;
      rd        <= 1'b0;  // Starts negative
    end else begin
      dec_valid <= sym_valid;
      if (sym_valid) begin
        rd <= rd_out;
      end
    end
  end

  always_ff @(posedge bitCLK) begin
    if (sym_valid) begin
      dec_data <= {r4[2:0], r6[4:0]};
      dec_k    <= is_k28 || is_kx7;
      dec_err  <= !r6[5] || !r4[3] || disp_err;
    end
  end

  a_one_cycle_latency: assert property (
    @(posedge bitCLK) disable iff (rst) dec_valid == $past(sym_valid)
  ) else $error("dec_valid does not follow sym_valid by one cycle");

endmodule

//--- source/elink_rx_fifo.sv
// Receive FIFO stage, classifies decoded symbols, drops idles and keeps error and overflow counts for the APB block
`timescale 1ns/1ps
`include "elink_defines.svh"

module elink_rx_fifo (
  input  logic                bitCLK,
  input  logic                rst,
  input  logic                enable,
  input  logic                clear,          // Zeroes both counters
  input  logic [7:0]          dec_data,
  input  logic                dec_k,
  input  logic                dec_err,
  input  logic                dec_valid,
  input  logic                pop,            // Empty check done upstream
  output elink_pkg::rx_word_t rd_word,        // Show-ahead head word
  output logic [4:0]          level,
  output logic [7:0]          overflow_count,
  output logic [7:0]          error_count
);

  localparam int         addr_w     = $clog2(`ELINK_FIFO_DEPTH);
  localparam logic [4:0] full_level = 5'(`ELINK_FIFO_DEPTH);

  elink_pkg::rx_word_t mem [`ELINK_FIFO_DEPTH];
  elink_pkg::rx_word_t wr_word;
  logic [addr_w-1:0]   wr_ptr;
  logic [addr_w-1:0]   rd_ptr;
  logic                is_idle;
  logic                full;
  logic                wr_req;
  logic                wr_en;

  // Symbol kind, errors take priority
  always_comb begin
    wr_word.data = dec_data;
    wr_word.kind = elink_pkg::kind_data;
    is_idle      = 1'b0;
    if (dec_err) begin
      wr_word.kind = elink_pkg::kind_err;
    end else if (dec_k) begin
      if (dec_data == `ELINK_K28_1) begin
        wr_word.kind = elink_pkg::kind_sop;
      end else if (dec_data == `ELINK_K28_6) begin
        wr_word.kind = elink_pkg::kind_eop;
      end else begin
        is_idle = 1'b1;  // Commas and other K codes
      end
    end
  end

  assign full    = (level == full_level);
  assign wr_req  = dec_valid && enable && !is_idle;
  assign wr_en   = wr_req && !full;     // Link cannot be stalled
  assign rd_word = mem[rd_ptr];

  always_ff @(posedge bitCLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_word;
    end
  end

  always_ff @(posedge bitCLK) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= 5'd0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, pop})
        2'b10:   level <= level + 5'd1;
        2'b01:   level <= level - 5'd1;
        default: level <= level;
      endcase
    end
  end

  // Saturating counters
  always_ff @(posedge bitCLK) begin
    if (rst || clear) begin
      overflow_count <= 8'd0;
      error_count    <= 8'd0;
    end else begin
      if (wr_req && full && overflow_count != 8'hFF) begin
        overflow_count <= overflow_count + 8'd1;
      end
      if (dec_valid && dec_err && error_count != 8'hFF) begin
        error_count <= error_count + 8'd1;  // Counted even when disabled
      end
    end
  end

  // APB side must never pop an empty FIFO
  a_no_empty_pop: assert property (
    @(posedge bitCLK) disable iff (rst) pop |-> (level != 5'd0)
  ) else $error("pop while FIFO empty");

  a_no_write_past_full: assert property (
    @(posedge bitCLK) disable iff (rst) level <= full_level
  ) else $error("FIFO level above depth");

endmodule

//--- source/elink_apb_regs.sv
// APB slave of the e-link receiver, gives the host FIFO pops, status, control and the error counters
`timescale 1ns/1ps
`include "elink_defines.svh"

module elink_apb_regs (
  input  logic                bitCLK,
  input  logic                rst,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [3:0]          paddr,
  input  logic [31:0]         pwdata,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  input  elink_pkg::rx_word_t rd_word,
  input  logic [4:0]          level,
  input  logic                locked,
  input  logic [7:0]          overflow_count,
  input  logic [7:0]          error_count,
  output logic                pop,
  output logic                enable,
  output logic                clear
);

  logic access;      // Access phase, transfer completes here
  logic sel_data;
  logic sel_status;
  logic sel_ctrl;
  logic not_empty;
  logic ctrl_write;

  assign access     = psel && penable;
  assign sel_data   = (paddr == `ELINK_ADDR_DATA);
  assign sel_status = (paddr == `ELINK_ADDR_STATUS);
  assign sel_ctrl   = (paddr == `ELINK_ADDR_CTRL);
  assign not_empty  = (level != 5'd0);
  assign ctrl_write = access && pwrite && sel_ctrl;

  assign pready  = 1'b1;  // No wait states
  assign pslverr = access && !(sel_data || sel_status || sel_ctrl);

  // Only place where the empty test is made
  assign pop   = access && !pwrite && sel_data && not_empty;
  assign clear = ctrl_write && pwdata[1];  // Self-clearing bit

  always_ff @(posedge bitCLK) begin
    if (rst) begin
      enable <= 1'b0;
    end else if (ctrl_write) begin
      enable <= pwdata[0];
    end
  end

  // Read mux
  always_comb begin
    prdata = 32'd0;
    if (sel_data) begin
      if (not_empty) begin
        prdata = {1'b1, 21'd0, rd_word};  // Valid, kind, byte
      end
    end else if (sel_status) begin
      prdata = {overflow_count, error_count, 7'd0, locked, 3'd0, level};
    end else if (sel_ctrl) begin
      prdata = {31'd0, enable};
    end
  end

  a_penable_with_psel: assert property (
    @(posedge bitCLK) disable iff (rst) penable |-> psel
  ) else $error("penable without psel");

endmodule

//--- source/elink_rx_top.sv
// Top of the e-link receiver, links the line input through aligner, decoder and FIFO to the APB slave
`timescale 1ns/1ps

module elink_rx_top (
  input  logic        bitCLK,
  input  logic        rst,
  input  logic [1:0]  elink_2bit,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [3:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);

  logic [9:0]          sym_10b;
  logic                sym_valid;
  logic                locked;
  logic [7:0]          dec_data;
  logic                dec_k;
  logic                dec_err;
  logic                dec_valid;
  elink_pkg::rx_word_t rd_word;
  logic [4:0]          level;
  logic [7:0]          overflow_count;
  logic [7:0]          error_count;
  logic                pop;
  logic                enable;
  logic                clear;

  // Bit alignment on K28.5
  elink_deserializer u_deser (
    .bitCLK     (bitCLK),
    .rst        (rst),
    .elink_2bit (elink_2bit),
    .sym_10b    (sym_10b),
    .sym_valid  (sym_valid),
    .locked     (locked)
  );

  dec_8b10b u_dec (
    .bitCLK    (bitCLK),
    .rst       (rst),
    .sym_10b   (sym_10b),
    .sym_valid (sym_valid),
    .dec_data  (dec_data),
    .dec_k     (dec_k),
    .dec_err   (dec_err),
    .dec_valid (dec_valid)
  );

  elink_rx_fifo u_fifo (
    .bitCLK         (bitCLK),
    .rst            (rst),
    .enable         (enable),
    .clear          (clear),
    .dec_data       (dec_data),
    .dec_k          (dec_k),
    .dec_err        (dec_err),
    .dec_valid      (dec_valid),
    .pop            (pop),
    .rd_word        (rd_word),
    .level          (level),
    .overflow_count (overflow_count),
    .error_count    (error_count)
  );

  // Host side
  elink_apb_regs u_regs (
    .bitCLK         (bitCLK),
    .rst            (rst),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .rd_word        (rd_word),
    .level          (level),
    .locked         (locked),
    .overflow_count (overflow_count),
    .error_count    (error_count),
    .pop            (pop),
    .enable         (enable),
    .clear          (clear)
  );

endmodule

//--- verification/elink_tb_encoder.svh
// 8b10b encoder model of the testbench, included inside the testbench module to build line symbols
`ifndef ELINK_TB_ENCODER_SVH
`define ELINK_TB_ENCODER_SVH

logic enc_rd = 1'b0;  // Running disparity of the model, 1 is positive

// 5b to 6b, RD- forms
function automatic logic [5:0] code6(input logic [4:0] x);
  logic [5:0] t [32];
  t = '{6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001,
        6'b011001, 6'b111000, 6'b111001, 6'b100101, 6'b010101, 6'b110100,
        6'b001101, 6'b101100, 6'b011100, 6'b010111, 6'b011011, 6'b100011,
        6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110,
        6'b011110, 6'b101011};
  return t[x];
endfunction

// Encodes one byte and moves the model disparity along
function automatic logic [9:0] enc_8b10b(input logic [7:0] d, input logic k);
  logic [5:0] c6;
  logic [3:0] c4;
  logic [9:0] sym;
  logic       rd_mid;
  c6 = code6(d[4:0]);
  if (k) begin
    c6 = 6'b001111;  // K28 only
    c4 = (d[7:5] == 3'd1) ? 4'b1001 : ((d[7:5] == 3'd6) ? 4'b0110 : 4'b1010);
    sym = enc_rd ? ~{c6, c4} : {c6, c4};
  end else begin
    if (enc_rd && ($countones(c6) != 3 || d[4:0] == 5'd7)) begin
      c6 = ~c6;
    end
    rd_mid = ($countones(c6) > 3) ? 1'b1 : (($countones(c6) < 3) ? 1'b0 : enc_rd);
    case (d[7:5])
      3'd0: c4 = 4'b1011;
      3'd1: c4 = 4'b1001;
      3'd2: c4 = 4'b0101;
      3'd3: c4 = 4'b1100;
      3'd4: c4 = 4'b1101;
      3'd5: c4 = 4'b1010;
      3'd6: c4 = 4'b0110;
      default: begin
        // Alternate 7 avoids a run of five
        if ((!rd_mid && d[4:0] inside {5'd17, 5'd18, 5'd20}) ||
            (rd_mid && d[4:0] inside {5'd11, 5'd13, 5'd14})) begin
          c4 = 4'b0111;
        end else begin
          c4 = 4'b1110;
        end
      end
    endcase
    if (rd_mid && ($countones(c4) != 2 || d[7:5] == 3'd3)) begin
      c4 = ~c4;
    end
    sym = {c6, c4};
  end
  if ($countones(sym) > 5) enc_rd = 1'b1;
  else if ($countones(sym) < 5) enc_rd = 1'b0;
  return sym;
endfunction

`endif

//--- verification/tb_elink_rx.sv
// Directed testbench of the e-link receiver, drives the line and APB and checks words, status and errors
`timescale 1ns/1ps
`include "elink_defines.svh"

module tb_elink_rx;

  `include "elink_tb_encoder.svh"

  localparam logic [9:0] bad_sym = 10'b1111000010;  // Invalid 6b block, leaves RD-

  logic        bitCLK;
  logic        rst;
  logic [1:0]  elink_2bit;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [3:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  logic        line_on;
  logic        bitq [$];         // Bits waiting for the line, earliest first
  logic [9:0]  symq [$];         // {raw, k, byte}
  logic [31:0] lcg_state = 32'd58;
  logic [7:0]  sent [$];
  logic [31:0] rd;
  logic        err;

  elink_rx_top uut (
    .bitCLK(bitCLK), .rst(rst), .elink_2bit(elink_2bit),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
  );

  initial begin
    bitCLK = 1'b0;
    forever #10 bitCLK = ~bitCLK;
  end

  function automatic logic [7:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  task automatic fail(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    $display("sim failed");
    $fatal(1, "stopping on first error");
  endtask

  // Line driver, idle commas whenever nothing is queued
  initial begin
    logic [9:0]  e;
    logic [9:0]  code;
    logic        b1;
    forever begin
      @(posedge bitCLK);
      #2;
      if (!line_on) begin
        elink_2bit = 2'b00;
      end else begin
        if (bitq.size() < 2) begin
          e = (symq.size() > 0) ? symq.pop_front() : {2'b01, 8'hBC};
          if (e[9]) begin
            code   = bad_sym;
            enc_rd = 1'b0;  // Decoder resyncs to RD- on this pattern
          end else begin
            code = enc_8b10b(e[7:0], e[8]);
          end
          for (int i = 9; i >= 0; i--) bitq.push_back(code[i]);  // Bit a first
        end
        b1 = bitq.pop_front();
        elink_2bit = {b1, bitq.pop_front()};
      end
    end
  end

  task automatic send_symbol(input logic [7:0] d, input logic k);
    symq.push_back({1'b0, k, d});
  endtask

  task automatic wait_line_idle();
    int n;
    n = 0;
    while (symq.size() > 0) begin
      @(posedge bitCLK);
      n++;
      if (n > 2000) fail("timeout waiting for the line queue to drain");
    end
    repeat (15) @(posedge bitCLK);  // Last symbol through decoder and FIFO
  endtask

  task automatic apb_access(input logic wr, input logic [3:0] a, input logic [31:0] wd,
                            output logic [31:0] rdat, output logic perr);
    int n;
    @(posedge bitCLK);
    #2;
    psel = 1'b1;
    pwrite = wr;
    paddr = a;
    pwdata = wd;
    @(posedge bitCLK);
    #2;
    penable = 1'b1;
    n = 0;
    #1;
    while (!pready) begin
      @(posedge bitCLK);
      #3;
      n++;
      if (n > 10) fail("pready stayed low");
    end
    rdat = prdata;
    perr = pslverr;
    @(posedge bitCLK);  // Transfer completes here
    #2;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] a, input logic [31:0] wd);
    logic [31:0] dummy;
    logic        e;
    apb_access(1'b1, a, wd, dummy, e);
    if (e) fail("pslverr on a valid write");
  endtask

  task automatic apb_read(input logic [3:0] a, output logic [31:0] rdat);
    logic e;
    apb_access(1'b0, a, 32'd0, rdat, e);
    if (e) fail("pslverr on a valid read");
  endtask

  task automatic check_word(input logic [31:0] got, input elink_pkg::rx_word_t exp);
    if (got[31] !== 1'b1 || got[9:0] !== exp) begin
      $display("FAIL %0t: word %h, expected valid kind %0d data %h",
               $time, got, exp.kind, exp.data);
      fail("wrong FIFO word");
    end
  endtask

  task automatic check_kind(input logic [31:0] got, input elink_pkg::sym_kind_e exp);
    if (got[31] !== 1'b1 || got[9:8] !== exp) begin
      $display("FAIL %0t: word %h, expected kind %0d", $time, got, exp);
      fail("wrong FIFO word kind");
    end
  endtask

  task automatic check_status(input logic [4:0] lvl, input logic lck,
                              input logic [7:0] errs, input logic [7:0] ovf);
    logic [31:0] st;
    apb_read(`ELINK_ADDR_STATUS, st);
    if (st[4:0] !== lvl || st[8] !== lck || st[23:16] !== errs || st[31:24] !== ovf) begin
      $display("FAIL %0t: status %h, expected level %0d lock %0d err %0d ovf %0d",
               $time, st, lvl, lck, errs, ovf);
      fail("wrong STATUS");
    end
  endtask

  task automatic wait_level(input logic [4:0] lvl);
    logic [31:0] st;
    int n;
    n = 0;
    apb_read(`ELINK_ADDR_STATUS, st);
    while (st[4:0] != lvl) begin
      n++;
      if (n > 300) fail("timeout waiting for FIFO level");
      apb_read(`ELINK_ADDR_STATUS, st);
    end
  endtask

  task automatic check_empty();
    apb_read(`ELINK_ADDR_DATA, rd);
    if (rd !== 32'd0) fail("DATA read of an empty FIFO is not zero");
  endtask

  task automatic send_bytes(input int n);
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      b = lcg_next();
      sent.push_back(b);
      send_symbol(b, 1'b0);
    end
  endtask

  task automatic read_sent(input int n);
    for (int i = 0; i < n; i++) begin
      apb_read(`ELINK_ADDR_DATA, rd);
      check_word(rd, '{elink_pkg::kind_data, sent.pop_front()});
    end
  endtask

  task automatic test_reset_disable();
    check_status(5'd0, 1'b0, 8'd0, 8'd0);
    check_empty();
    line_on = 1'b1;
    repeat (4) send_symbol(8'hBC, 1'b1);
    send_bytes(4);
    wait_line_idle();
    sent.delete();
    check_status(5'd0, 1'b1, 8'd0, 8'd0);
  endtask

  task automatic test_data_order();
    apb_write(`ELINK_ADDR_CTRL, 32'd1);
    repeat (4) send_symbol(8'hBC, 1'b1);
    send_bytes(12);
    wait_level(5'd12);
    read_sent(12);
    check_empty();
  endtask

  task automatic test_delimiters();
    send_symbol(`ELINK_K28_1, 1'b1);
    send_bytes(3);
    send_symbol(`ELINK_K28_6, 1'b1);
    repeat (3) send_symbol(8'hBC, 1'b1);
    wait_line_idle();
    check_status(5'd5, 1'b1, 8'd0, 8'd0);
    apb_read(`ELINK_ADDR_DATA, rd);
    check_word(rd, '{elink_pkg::kind_sop, `ELINK_K28_1});
    read_sent(3);
    apb_read(`ELINK_ADDR_DATA, rd);
    check_word(rd, '{elink_pkg::kind_eop, `ELINK_K28_6});
    check_empty();
  endtask

  task automatic test_code_error();
    apb_write(`ELINK_ADDR_CTRL, 32'd3);  // Enable held, counters cleared
    send_bytes(1);
    symq.push_back({1'b1, 9'd0});
    send_bytes(1);
    wait_line_idle();
    check_status(5'd3, 1'b1, 8'd1, 8'd0);
    read_sent(1);
    apb_read(`ELINK_ADDR_DATA, rd);
    check_kind(rd, elink_pkg::kind_err);
    read_sent(1);
    apb_write(`ELINK_ADDR_CTRL, 32'd3);
    check_status(5'd0, 1'b1, 8'd0, 8'd0);
  endtask

  task automatic test_overflow();
    send_bytes(20);
    wait_line_idle();
    check_status(5'd16, 1'b1, 8'd0, 8'd4);
    read_sent(16);
    sent.delete();  // Last four were dropped
    check_empty();
  endtask

  task automatic test_badaddr_realign();
    int n;
    apb_access(1'b0, 4'hC, 32'd0, rd, err);
    if (err !== 1'b1) fail("no pslverr on read of address 0xC");
    bitq.push_front(1'b0);  // One-bit slip of the line
    repeat (6) send_symbol(8'hBC, 1'b1);
    wait_line_idle();
    n = 0;
    apb_read(`ELINK_ADDR_DATA, rd);
    while (rd[31]) begin  // Drop words decoded while misaligned
      n++;
      if (n > 20) fail("FIFO did not drain after the slip");
      apb_read(`ELINK_ADDR_DATA, rd);
    end
    apb_write(`ELINK_ADDR_CTRL, 32'd3);
    send_bytes(3);
    wait_level(5'd3);
    read_sent(3);
    check_status(5'd0, 1'b1, 8'd0, 8'd0);
  endtask

  initial begin
    #200000;
    $display("Global timeout, simulation did not finish");
    $display("sim failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    rst = 1'b1;
    elink_2bit = 2'b00;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = 4'h0;
    pwdata = 32'd0;
    line_on = 1'b0;
    repeat (5) @(posedge bitCLK);
    #2;
    rst = 1'b0;
    test_reset_disable();
    test_data_order();
    test_delimiters();
    test_code_error();
    test_overflow();
    test_badaddr_realign();
    $display("sim passed");
    $finish;
  end

endmodule

//--- sim.f
+incdir+source
+incdir+verification
source/elink_pkg.sv
source/elink_deserializer.sv
source/dec_8b10b.sv
source/elink_rx_fifo.sv
source/elink_apb_regs.sv
source/elink_rx_top.sv
verification/tb_elink_rx.sv
